/* hdl/axi_pkg.sv */
// ----------------------------------------------------------------------
// AXI4 field types and width constants shared by the engines, the
// memory and the bus interface.
// ----------------------------------------------------------------------
package axi_pkg;

	typedef enum logic [1:0] {
		FIXED = 2'b00,
		INCR  = 2'b01,
		WRAP  = 2'b10
	} axi_burst_t;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_t;

	// beat count minus one, as carried on AxLEN.
	typedef logic [7:0] axi_len_t;

	localparam logic [2:0] AXI_SIZE_WORD = 3'd2;

	// a larger encoding is a worse response.
	function automatic axi_resp_t resp_max(input axi_resp_t a, input axi_resp_t b);
		return (b > a) ? b : a;
	endfunction

endpackage

/* hdl/bfm_regs_pkg.sv */
// ----------------------------------------------------------------------
// APB register map of the burst master: offsets, bit positions and the
// depth of the burst data buffers.
// ----------------------------------------------------------------------
package bfm_regs_pkg;

	localparam int APB_ADDR_WIDTH = 8;

	localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL   = 8'h00;
	localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS = 8'h04;
	localparam logic [APB_ADDR_WIDTH-1:0] REG_ADDR   = 8'h08;
	localparam logic [APB_ADDR_WIDTH-1:0] REG_CMD    = 8'h0C;
	localparam logic [APB_ADDR_WIDTH-1:0] WBUF_BASE  = 8'h40;
	localparam logic [APB_ADDR_WIDTH-1:0] RBUF_BASE  = 8'h80;

	localparam int BUF_DEPTH = 16;
	localparam int BUF_IDX_WIDTH = $clog2(BUF_DEPTH);

	localparam int CTRL_START_WR = 0;
	localparam int CTRL_START_RD = 1;

	localparam int STAT_WR_BUSY = 0;
	localparam int STAT_RD_BUSY = 1;
	localparam int STAT_BRESP_LSB = 2;
	localparam int STAT_RRESP_LSB = 4;

	localparam int CMD_LEN_LSB = 0;
	localparam int CMD_BURST_LSB = 8;
	localparam int CMD_ID_LSB = 12;

endpackage

/* hdl/axi4_if.sv */
// ----------------------------------------------------------------------
// AXI4 bus between the engines and the memory, and the command port
// between the register block and each engine.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

interface axi4_if #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int ID_WIDTH = 4
);
	logic [ID_WIDTH-1:0] awid;
	logic [ADDR_WIDTH-1:0] awaddr;
	axi_pkg::axi_len_t awlen;
	logic [2:0] awsize;
	axi_pkg::axi_burst_t awburst;
	logic awvalid;
	logic awready;
	logic [DATA_WIDTH-1:0] wdata;
	logic [DATA_WIDTH/8-1:0] wstrb;
	logic wlast;
	logic wvalid;
	logic wready;
	logic [ID_WIDTH-1:0] bid;
	axi_pkg::axi_resp_t bresp;
	logic bvalid;
	logic bready;
	logic [ID_WIDTH-1:0] arid;
	logic [ADDR_WIDTH-1:0] araddr;
	axi_pkg::axi_len_t arlen;
	logic [2:0] arsize;
	axi_pkg::axi_burst_t arburst;
	logic arvalid;
	logic arready;
	logic [ID_WIDTH-1:0] rid;
	logic [DATA_WIDTH-1:0] rdata;
	axi_pkg::axi_resp_t rresp;
	logic rlast;
	logic rvalid;
	logic rready;

	modport master (
		output awid, awaddr, awlen, awsize, awburst, awvalid,
		output wdata, wstrb, wlast, wvalid, bready,
		output arid, araddr, arlen, arsize, arburst, arvalid, rready,
		input awready, wready, bid, bresp, bvalid,
		input arready, rid, rdata, rresp, rlast, rvalid
	);

	modport slave (
		input awid, awaddr, awlen, awsize, awburst, awvalid,
		input wdata, wstrb, wlast, wvalid, bready,
		input arid, araddr, arlen, arsize, arburst, arvalid, rready,
		output awready, wready, bid, bresp, bvalid,
		output arready, rid, rdata, rresp, rlast, rvalid
	);
endinterface

interface burst_port_if #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int ID_WIDTH = 4
);
	logic start;
	logic [ADDR_WIDTH-1:0] addr;
	axi_pkg::axi_len_t len;
	logic [ID_WIDTH-1:0] id;
	axi_pkg::axi_burst_t burst;
	logic [DATA_WIDTH-1:0] buf_rdata;
	logic busy;
	axi_pkg::axi_resp_t resp;
	logic [bfm_regs_pkg::BUF_IDX_WIDTH-1:0] buf_idx;
	logic [DATA_WIDTH-1:0] buf_wdata;
	logic buf_we;

	modport ctrl (
		output start, addr, len, id, burst, buf_rdata,
		input busy, resp, buf_idx, buf_wdata, buf_we
	);

	modport engine (
		input start, addr, len, id, burst, buf_rdata,
		output busy, resp, buf_idx, buf_wdata, buf_we
	);
endinterface

/* hdl/burst_regs.sv */
// ----------------------------------------------------------------------
// APB slave with the burst settings, the write and read data buffers
// and the engine status word.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module burst_regs #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int ID_WIDTH = 4
) (
	input logic clk,
	input logic rstn,
	input logic [bfm_regs_pkg::APB_ADDR_WIDTH-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [DATA_WIDTH-1:0] pwdata,
	output logic [DATA_WIDTH-1:0] prdata,
	output logic pready,
	output logic pslverr,
	burst_port_if.ctrl wr,
	burst_port_if.ctrl rd
);
	localparam int MAX_LEN = bfm_regs_pkg::BUF_DEPTH - 1;
	localparam int BUF_BYTES = 4 * bfm_regs_pkg::BUF_DEPTH;

	logic [ADDR_WIDTH-1:0] addr_q;
	axi_pkg::axi_len_t len_q;
	axi_pkg::axi_burst_t burst_q;
	logic [ID_WIDTH-1:0] id_q;
	logic start_wr_q;
	logic start_rd_q;
	logic [DATA_WIDTH-1:0] wbuf [bfm_regs_pkg::BUF_DEPTH];
	logic [DATA_WIDTH-1:0] rbuf [bfm_regs_pkg::BUF_DEPTH];
	logic [DATA_WIDTH-1:0] status;
	logic [DATA_WIDTH-1:0] cmd_word;
	logic [bfm_regs_pkg::BUF_IDX_WIDTH-1:0] buf_sel;
	logic access;
	logic hit_wbuf;
	logic hit_rbuf;
	logic err;
	logic wr_en;

	assign access = psel && penable;
	assign wr_en = access && pwrite && !err;
	assign pready = 1'b1;
	assign pslverr = access && err;
	assign buf_sel = paddr[bfm_regs_pkg::BUF_IDX_WIDTH+1:2];
	assign hit_wbuf = paddr >= bfm_regs_pkg::WBUF_BASE &&
		paddr < bfm_regs_pkg::WBUF_BASE + BUF_BYTES;
	assign hit_rbuf = paddr >= bfm_regs_pkg::RBUF_BASE &&
		paddr < bfm_regs_pkg::RBUF_BASE + BUF_BYTES;

	always_comb begin
		status = '0;
		status[bfm_regs_pkg::STAT_WR_BUSY] = wr.busy;
		status[bfm_regs_pkg::STAT_RD_BUSY] = rd.busy;
		status[bfm_regs_pkg::STAT_BRESP_LSB +: 2] = wr.resp;
		status[bfm_regs_pkg::STAT_RRESP_LSB +: 2] = rd.resp;
		cmd_word = '0;
		cmd_word[bfm_regs_pkg::CMD_LEN_LSB +: 8] = len_q;
		cmd_word[bfm_regs_pkg::CMD_BURST_LSB +: 2] = burst_q;
		cmd_word[bfm_regs_pkg::CMD_ID_LSB +: ID_WIDTH] = id_q;
	end

	// read data and error flag for the offset on the bus.
	always_comb begin
		prdata = '0;
		err = 1'b0;
		if (hit_wbuf) begin
			prdata = wbuf[buf_sel];
		end else if (hit_rbuf) begin
			prdata = rbuf[buf_sel];
			err = pwrite;
		end else begin
			case (paddr)
				bfm_regs_pkg::REG_CTRL: prdata = '0;
				bfm_regs_pkg::REG_STATUS: begin
					prdata = status;
					err = pwrite;
				end
				bfm_regs_pkg::REG_ADDR: prdata = DATA_WIDTH'(addr_q);
				bfm_regs_pkg::REG_CMD: prdata = cmd_word;
				default: err = 1'b1;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			addr_q <= '0;
			len_q <= '0;
			burst_q <= axi_pkg::INCR;
			id_q <= '0;
			start_wr_q <= 1'b0;
			start_rd_q <= 1'b0;
		end else begin
			// a start for an engine that is still busy is dropped.
			start_wr_q <= wr_en && paddr == bfm_regs_pkg::REG_CTRL &&
				pwdata[bfm_regs_pkg::CTRL_START_WR] && !wr.busy;
			start_rd_q <= wr_en && paddr == bfm_regs_pkg::REG_CTRL &&
				pwdata[bfm_regs_pkg::CTRL_START_RD] && !rd.busy;
			if (wr_en && paddr == bfm_regs_pkg::REG_ADDR) begin
				addr_q <= pwdata[ADDR_WIDTH-1:0];
			end
			if (wr_en && paddr == bfm_regs_pkg::REG_CMD) begin
				if (pwdata[bfm_regs_pkg::CMD_LEN_LSB +: 8] > MAX_LEN) begin
					len_q <= axi_pkg::axi_len_t'(MAX_LEN);
				end else begin
					len_q <= pwdata[bfm_regs_pkg::CMD_LEN_LSB +: 8];
				end
				burst_q <= axi_pkg::axi_burst_t'(pwdata[bfm_regs_pkg::CMD_BURST_LSB +: 2]);
				id_q <= pwdata[bfm_regs_pkg::CMD_ID_LSB +: ID_WIDTH];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en && hit_wbuf) begin
			wbuf[buf_sel] <= pwdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < bfm_regs_pkg::BUF_DEPTH; i++) begin
				rbuf[i] <= '0;
			end
		end else if (rd.buf_we) begin
			rbuf[rd.buf_idx] <= rd.buf_wdata;
		end
	end

	assign wr.start = start_wr_q;
	assign wr.addr = addr_q;
	assign wr.len = len_q;
	assign wr.id = id_q;
	assign wr.burst = burst_q;
	assign wr.buf_rdata = wbuf[wr.buf_idx];
	assign rd.start = start_rd_q;
	assign rd.addr = addr_q;
	assign rd.len = len_q;
	assign rd.id = id_q;
	assign rd.burst = burst_q;
	assign rd.buf_rdata = rbuf[rd.buf_idx];
endmodule

/* hdl/axi_write_master.sv */
// ----------------------------------------------------------------------
// Write engine: sends one AW request, its W beats from the write buffer
// and waits for the B response.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module axi_write_master #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int ID_WIDTH = 4
) (
	input logic clk,
	input logic rstn,
	burst_port_if.engine cmd,
	axi4_if.master axi
);
	typedef enum logic [1:0] {st_idle, st_addr, st_data, st_resp} state_t;

	state_t state;
	logic [ADDR_WIDTH-1:0] addr_q;
	axi_pkg::axi_len_t len_q;
	logic [ID_WIDTH-1:0] id_q;
	axi_pkg::axi_burst_t burst_q;
	axi_pkg::axi_len_t beat;
	axi_pkg::axi_resp_t resp_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= st_idle;
			beat <= '0;
			resp_q <= axi_pkg::OKAY;
		end else begin
			case (state)
				st_idle: begin
					if (cmd.start) begin
						beat <= '0;
						state <= st_addr;
					end
				end
				st_addr: begin
					if (axi.awready) begin
						state <= st_data;
					end
				end
				st_data: begin
					if (axi.wready) begin
						if (beat == len_q) begin
							state <= st_resp;
						end else begin
							beat <= beat + 8'd1;
						end
					end
				end
				st_resp: begin
					if (axi.bvalid) begin
						resp_q <= axi.bresp;
						state <= st_idle;
					end
				end
			endcase
		end
	end

	// the request is copied at start so the host may reprogram meanwhile.
	always_ff @(posedge clk) begin
		if (state == st_idle && cmd.start) begin
			addr_q <= cmd.addr;
			len_q <= cmd.len;
			id_q <= cmd.id;
			burst_q <= cmd.burst;
		end
	end

	assign axi.awid = id_q;
	assign axi.awaddr = addr_q;
	assign axi.awlen = len_q;
	assign axi.awsize = axi_pkg::AXI_SIZE_WORD;
	assign axi.awburst = burst_q;
	assign axi.awvalid = state == st_addr;
	assign axi.wdata = cmd.buf_rdata;
	assign axi.wstrb = '1;
	assign axi.wlast = state == st_data && beat == len_q;
	assign axi.wvalid = state == st_data;
	assign axi.bready = state == st_resp;

	assign cmd.busy = state != st_idle;
	assign cmd.resp = resp_q;
	assign cmd.buf_idx = beat[bfm_regs_pkg::BUF_IDX_WIDTH-1:0];
	assign cmd.buf_wdata = '0;
	assign cmd.buf_we = 1'b0;

	// the request stays on the bus, unchanged, until the memory takes it.
	assert property (@(posedge clk) disable iff (!rstn)
		axi.awvalid && !axi.awready |=>
			axi.awvalid && $stable(axi.awaddr) && $stable(axi.awlen));

	// the memory answers only once WLAST has closed the burst on our side.
	assert property (@(posedge clk) disable iff (!rstn)
		axi.bvalid |-> state == st_resp);
endmodule

/* hdl/axi_read_master.sv */
// ----------------------------------------------------------------------
// Read engine: sends one AR request and stores the returned beats in
// the read buffer.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module axi_read_master #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int ID_WIDTH = 4
) (
	input logic clk,
	input logic rstn,
	burst_port_if.engine cmd,
	axi4_if.master axi
);
	typedef enum logic [1:0] {st_idle, st_addr, st_data} state_t;

	state_t state;
	logic [ADDR_WIDTH-1:0] addr_q;
	axi_pkg::axi_len_t len_q;
	logic [ID_WIDTH-1:0] id_q;
	axi_pkg::axi_burst_t burst_q;
	axi_pkg::axi_len_t beat;
	axi_pkg::axi_resp_t acc;
	axi_pkg::axi_resp_t resp_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= st_idle;
			beat <= '0;
			acc <= axi_pkg::OKAY;
			resp_q <= axi_pkg::OKAY;
		end else begin
			case (state)
				st_idle: begin
					if (cmd.start) begin
						beat <= '0;
						acc <= axi_pkg::OKAY;
						state <= st_addr;
					end
				end
				st_addr: begin
					if (axi.arready) begin
						state <= st_data;
					end
				end
				st_data: begin
					if (axi.rvalid) begin
						acc <= axi_pkg::resp_max(acc, axi.rresp);
						beat <= beat + 8'd1;
						if (axi.rlast) begin
							resp_q <= axi_pkg::resp_max(acc, axi.rresp);
							state <= st_idle;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && cmd.start) begin
			addr_q <= cmd.addr;
			len_q <= cmd.len;
			id_q <= cmd.id;
			burst_q <= cmd.burst;
		end
	end

	assign axi.arid = id_q;
	assign axi.araddr = addr_q;
	assign axi.arlen = len_q;
	assign axi.arsize = axi_pkg::AXI_SIZE_WORD;
	assign axi.arburst = burst_q;
	assign axi.arvalid = state == st_addr;
	assign axi.rready = state == st_data;

	// every accepted beat lands in the buffer at its beat index.
	assign cmd.buf_we = state == st_data && axi.rvalid;
	assign cmd.buf_wdata = axi.rdata;
	assign cmd.buf_idx = beat[bfm_regs_pkg::BUF_IDX_WIDTH-1:0];
	assign cmd.busy = state != st_idle;
	assign cmd.resp = resp_q;

	assert property (@(posedge clk) disable iff (!rstn)
		axi.arvalid && !axi.arready |=>
			axi.arvalid && $stable(axi.araddr) && $stable(axi.arlen));
endmodule

/* hdl/axi_burst_mem.sv */
// ----------------------------------------------------------------------
// AXI4 memory slave of MEM_WORDS words with FIXED and INCR bursts.
// Beats outside the array or of other burst types answer SLVERR.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module axi_burst_mem #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int ID_WIDTH = 4,
	parameter int MEM_WORDS = 256
) (
	input logic clk,
	input logic rstn,
	axi4_if.slave axi
);
	localparam int IDX_WIDTH = $clog2(MEM_WORDS);

	typedef enum logic [1:0] {w_idle, w_accept, w_data, w_resp} wstate_t;
	typedef enum logic [1:0] {r_idle, r_accept, r_data} rstate_t;

	logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
	wstate_t wstate;
	rstate_t rstate;
	logic [ADDR_WIDTH-1:0] w_addr;
	logic [ADDR_WIDTH-1:0] r_addr;
	axi_pkg::axi_burst_t w_burst;
	axi_pkg::axi_burst_t r_burst;
	logic w_bad;
	logic r_bad;
	logic [ID_WIDTH-1:0] w_id;
	logic [ID_WIDTH-1:0] r_id;
	axi_pkg::axi_len_t w_len;
	axi_pkg::axi_len_t w_beat;
	axi_pkg::axi_len_t r_len;
	axi_pkg::axi_len_t r_beat;
	axi_pkg::axi_resp_t b_resp;
	logic w_ok;
	logic r_ok;

	function automatic logic in_range(input logic [ADDR_WIDTH-1:0] a);
		return {2'b00, a[ADDR_WIDTH-1:2]} < ADDR_WIDTH'(MEM_WORDS);
	endfunction

	function automatic logic burst_bad(input axi_pkg::axi_burst_t b, input logic [2:0] size);
		return !(b == axi_pkg::FIXED || b == axi_pkg::INCR) || size != axi_pkg::AXI_SIZE_WORD;
	endfunction

	function automatic logic [ADDR_WIDTH-1:0] next_addr(input logic [ADDR_WIDTH-1:0] a,
			input axi_pkg::axi_burst_t b);
		return (b == axi_pkg::INCR) ? a + ADDR_WIDTH'(4) : a;
	endfunction

	assign w_ok = !w_bad && in_range(w_addr);
	assign r_ok = !r_bad && in_range(r_addr);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wstate <= w_idle;
			w_beat <= '0;
			b_resp <= axi_pkg::OKAY;
		end else begin
			case (wstate)
				w_idle: if (axi.awvalid) wstate <= w_accept;
				w_accept: begin
					w_beat <= '0;
					b_resp <= axi_pkg::OKAY;
					wstate <= w_data;
				end
				w_data: begin
					if (axi.wvalid) begin
						w_beat <= w_beat + 8'd1;
						if (!w_ok) b_resp <= axi_pkg::SLVERR;
						if (axi.wlast) wstate <= w_resp;
					end
				end
				w_resp: if (axi.bready) wstate <= w_idle;
			endcase
		end
	end

	// only whole words are stored.
	always_ff @(posedge clk) begin
		if (wstate == w_accept) begin
			w_addr <= axi.awaddr;
			w_len <= axi.awlen;
			w_burst <= axi.awburst;
			w_id <= axi.awid;
			w_bad <= burst_bad(axi.awburst, axi.awsize);
		end else if (wstate == w_data && axi.wvalid) begin
			if (w_ok && &axi.wstrb) mem[w_addr[IDX_WIDTH+1:2]] <= axi.wdata;
			w_addr <= next_addr(w_addr, w_burst);
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			rstate <= r_idle;
			r_beat <= '0;
		end else begin
			case (rstate)
				r_idle: if (axi.arvalid) rstate <= r_accept;
				r_accept: begin
					r_beat <= '0;
					rstate <= r_data;
				end
				r_data: begin
					if (axi.rready) begin
						r_beat <= r_beat + 8'd1;
						if (r_beat == r_len) rstate <= r_idle;
					end
				end
				default: rstate <= r_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rstate == r_accept) begin
			r_addr <= axi.araddr;
			r_len <= axi.arlen;
			r_burst <= axi.arburst;
			r_id <= axi.arid;
			r_bad <= burst_bad(axi.arburst, axi.arsize);
		end else if (rstate == r_data && axi.rready) begin
			r_addr <= next_addr(r_addr, r_burst);
		end
	end

	assign axi.awready = wstate == w_accept;
	assign axi.wready = wstate == w_data;
	assign axi.bvalid = wstate == w_resp;
	assign axi.bresp = b_resp;
	assign axi.bid = w_id;
	assign axi.arready = rstate == r_accept;
	assign axi.rvalid = rstate == r_data;
	assign axi.rdata = r_ok ? mem[r_addr[IDX_WIDTH+1:2]] : '0;
	assign axi.rresp = r_ok ? axi_pkg::OKAY : axi_pkg::SLVERR;
	assign axi.rlast = r_beat == r_len;
	assign axi.rid = r_id;

	// the master's WLAST has to agree with the length it gave on AW.
	assert property (@(posedge clk) disable iff (!rstn)
		axi.wvalid && axi.wready |-> axi.wlast == (w_beat == w_len));
endmodule

/* hdl/axi_burst_top.sv */
// ----------------------------------------------------------------------
// Burst master top: APB register block, write and read engines and
// the AXI4 memory behind them.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module axi_burst_top #(
	parameter int ADDR_WIDTH = 32,
	parameter int DATA_WIDTH = 32,
	parameter int ID_WIDTH = 4,
	parameter int MEM_WORDS = 256
) (
	input logic clk,
	input logic rstn,
	input logic [bfm_regs_pkg::APB_ADDR_WIDTH-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [DATA_WIDTH-1:0] pwdata,
	output logic [DATA_WIDTH-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	burst_port_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH))
		wr_port ();
	burst_port_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH))
		rd_port ();
	axi4_if #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH))
		axi_bus ();

	burst_regs #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH))
	burst_regs_inst (
		.clk(clk),
		.rstn(rstn),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.wr(wr_port),
		.rd(rd_port)
	);

	axi_write_master #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH))
	axi_write_master_inst (.clk(clk), .rstn(rstn), .cmd(wr_port), .axi(axi_bus));

	axi_read_master #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .ID_WIDTH(ID_WIDTH))
	axi_read_master_inst (.clk(clk), .rstn(rstn), .cmd(rd_port), .axi(axi_bus));

	axi_burst_mem #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH),
		.ID_WIDTH(ID_WIDTH),
		.MEM_WORDS(MEM_WORDS)
	) axi_burst_mem_inst (
		.clk(clk),
		.rstn(rstn),
		.axi(axi_bus)
	);
endmodule

/* test/tb_axi_burst.sv */
// ----------------------------------------------------------------------
// Testbench for the AXI4 burst master: runs the burst commands of the
// pattern file over APB and checks them against a memory model.
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_axi_burst;
	localparam int DATA_WIDTH = 32;
	localparam int MEM_WORDS = 256;
	localparam int PAT_MAX = 64;
	localparam int PAT_COLS = 5;
	localparam int RESET_CYCLES = 16;
	// a pattern averages some fifteen APB transfers of three cycles, polls included.
	localparam int CYCLES_PER_PATTERN = 64;
	localparam int SETUP_CYCLES = 256;

	logic clk = 1'b0;
	logic rstn;
	logic [bfm_regs_pkg::APB_ADDR_WIDTH-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [DATA_WIDTH-1:0] pwdata;
	logic [DATA_WIDTH-1:0] prdata;
	logic pready;
	logic pslverr;

	logic [31:0] pat [PAT_MAX*PAT_COLS];
	logic [DATA_WIDTH-1:0] ref_mem [MEM_WORDS];
	logic [31:0] last_addr;
	int seed = 32'hb0946f2b;
	int npat;
	int limit;
	int cycles = 0;
	int resp_errors = 0;
	int word_errors = 0;
	int bit_errors = 0;
	int misc_errors = 0;

	axi_burst_top axi_burst_top_inst (
		.clk(clk),
		.rstn(rstn),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("timeout: the bursts did not finish within %0d cycles", limit);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic check_resp(input string name, input axi_pkg::axi_resp_t got,
			input axi_pkg::axi_resp_t exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			resp_errors++;
		end
	endtask

	task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] got,
			input logic [DATA_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			word_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			bit_errors++;
		end
	endtask

	// setup cycle, access cycle, and the response sampled mid access.
	task automatic apb_write(input logic [7:0] a, input logic [31:0] d, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= a;
		pwdata <= d;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		err = pslverr;
		check_bit("pready", pready, 1'b1);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] a, output logic [31:0] d, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= a;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		d = prdata;
		err = pslverr;
		check_bit("pready", pready, 1'b1);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] a, input logic [31:0] d);
		logic err;
		apb_write(a, d, err);
		check_bit("pslverr", err, 1'b0);
	endtask

	task automatic read_reg(input logic [7:0] a, output logic [31:0] d);
		logic err;
		apb_read(a, d, err);
		check_bit("pslverr", err, 1'b0);
	endtask

	task automatic wait_idle(input int bit_pos, output logic [31:0] status);
		do begin
			read_reg(bfm_regs_pkg::REG_STATUS, status);
		end while (status[bit_pos]);
	endtask

	function automatic logic beat_in_range(input logic [31:0] a, input axi_pkg::axi_burst_t b);
		return (b == axi_pkg::FIXED || b == axi_pkg::INCR) && (a >> 2) < MEM_WORDS;
	endfunction

	task automatic program_burst(input logic [31:0] addr, input axi_pkg::axi_len_t len,
			input axi_pkg::axi_burst_t burst, input logic [3:0] id);
		logic [31:0] cmd;
		cmd = '0;
		cmd[bfm_regs_pkg::CMD_LEN_LSB +: 8] = len;
		cmd[bfm_regs_pkg::CMD_BURST_LSB +: 2] = burst;
		cmd[bfm_regs_pkg::CMD_ID_LSB +: 4] = id;
		write_reg(bfm_regs_pkg::REG_ADDR, addr);
		write_reg(bfm_regs_pkg::REG_CMD, cmd);
		last_addr = addr;
	endtask

	// with drop_second set, a second start aimed elsewhere is written while busy.
	task automatic write_burst(input logic [31:0] addr, input axi_pkg::axi_len_t len,
			input axi_pkg::axi_burst_t burst, input axi_pkg::axi_resp_t exp,
			input logic drop_second, input logic [3:0] id);
		logic [DATA_WIDTH-1:0] data [bfm_regs_pkg::BUF_DEPTH];
		logic [31:0] status;
		logic [31:0] a;
		for (int i = 0; i <= int'(len); i++) begin
			data[i] = $random(seed);
			write_reg(bfm_regs_pkg::WBUF_BASE + 8'(4 * i), data[i]);
		end
		program_burst(addr, len, burst, id);
		write_reg(bfm_regs_pkg::REG_CTRL, 32'd1 << bfm_regs_pkg::CTRL_START_WR);
		if (drop_second) begin
			write_reg(bfm_regs_pkg::REG_ADDR, addr ^ 32'h200);
			last_addr = addr ^ 32'h200;
			write_reg(bfm_regs_pkg::REG_CTRL, 32'd1 << bfm_regs_pkg::CTRL_START_WR);
		end
		wait_idle(bfm_regs_pkg::STAT_WR_BUSY, status);
		check_resp("bresp", axi_pkg::axi_resp_t'(status[bfm_regs_pkg::STAT_BRESP_LSB +: 2]), exp);
		a = addr;
		for (int i = 0; i <= int'(len); i++) begin
			if (beat_in_range(a, burst)) begin
				ref_mem[a[9:2]] = data[i];
			end
			if (burst == axi_pkg::INCR) begin
				a = a + 32'd4;
			end
		end
	endtask

	task automatic read_burst(input logic [31:0] addr, input axi_pkg::axi_len_t len,
			input axi_pkg::axi_burst_t burst, input axi_pkg::axi_resp_t exp,
			input logic [3:0] id);
		logic [31:0] status;
		logic [31:0] a;
		logic [31:0] word;
		logic [DATA_WIDTH-1:0] exp_word;
		program_burst(addr, len, burst, id);
		write_reg(bfm_regs_pkg::REG_CTRL, 32'd1 << bfm_regs_pkg::CTRL_START_RD);
		wait_idle(bfm_regs_pkg::STAT_RD_BUSY, status);
		check_resp("rresp", axi_pkg::axi_resp_t'(status[bfm_regs_pkg::STAT_RRESP_LSB +: 2]), exp);
		a = addr;
		for (int i = 0; i <= int'(len); i++) begin
			exp_word = beat_in_range(a, burst) ? ref_mem[a[9:2]] : '0;
			read_reg(bfm_regs_pkg::RBUF_BASE + 8'(4 * i), word);
			check_word($sformatf("rbuf[%0d]", i), word, exp_word);
			if (burst == axi_pkg::INCR) begin
				a = a + 32'd4;
			end
		end
	endtask

	task automatic probe_bad_access(input logic [7:0] off);
		logic [31:0] word;
		logic err;
		apb_read(off, word, err);
		check_bit("pslverr", err, 1'b1);
		apb_write(off, 32'hffff_ffff, err);
		check_bit("pslverr", err, 1'b1);
		apb_write(bfm_regs_pkg::REG_STATUS, 32'hffff_ffff, err);
		check_bit("pslverr", err, 1'b1);
		apb_write(bfm_regs_pkg::RBUF_BASE, 32'hffff_ffff, err);
		check_bit("pslverr", err, 1'b1);
		read_reg(bfm_regs_pkg::REG_ADDR, word);
		check_word("prdata", word, last_addr);
	endtask

	initial begin
		logic [31:0] word;
		logic [31:0] op;
		logic [31:0] addr;
		rstn = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		last_addr = '0;
		for (int i = 0; i < PAT_MAX * PAT_COLS; i++) begin
			pat[i] = '1;
		end
		$readmemh("test/burst_patterns.txt", pat);
		npat = 0;
		while (npat < PAT_MAX && pat[npat * PAT_COLS] != '1) begin
			npat++;
		end
		limit = RESET_CYCLES + SETUP_CYCLES + npat * CYCLES_PER_PATTERN;

		repeat (RESET_CYCLES) @(posedge clk);
		rstn <= 1'b1;

		// status and the read buffer start out cleared.
		read_reg(bfm_regs_pkg::REG_STATUS, word);
		check_word("status", word, '0);
		for (int i = 0; i < bfm_regs_pkg::BUF_DEPTH; i++) begin
			read_reg(bfm_regs_pkg::RBUF_BASE + 8'(4 * i), word);
			check_word($sformatf("rbuf[%0d]", i), word, '0);
		end

		for (int p = 0; p < npat; p++) begin
			op = pat[p * PAT_COLS];
			addr = pat[p * PAT_COLS + 1];
			case (op)
				0, 2: write_burst(addr, pat[p * PAT_COLS + 2][7:0],
					axi_pkg::axi_burst_t'(pat[p * PAT_COLS + 3][1:0]),
					axi_pkg::axi_resp_t'(pat[p * PAT_COLS + 4][1:0]), op == 2, 4'(p));
				1: read_burst(addr, pat[p * PAT_COLS + 2][7:0],
					axi_pkg::axi_burst_t'(pat[p * PAT_COLS + 3][1:0]),
					axi_pkg::axi_resp_t'(pat[p * PAT_COLS + 4][1:0]), 4'(p));
				3: probe_bad_access(addr[7:0]);
				default: begin
					$display("pattern %0d has an unknown operation %0h", p, op);
					misc_errors++;
				end
			endcase
		end

		$display("errors: resp %0d, word %0d, bit %0d, other %0d",
			resp_errors, word_errors, bit_errors, misc_errors);
		if (resp_errors + word_errors + bit_errors + misc_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end
endmodule

/* test/burst_patterns.txt */
// op addr len burst resp, in hex. op: 0 write, 1 read, 2 write with a dropped
// second start to addr^200, 3 APB error probe at addr. burst: 0 FIXED 1 INCR 2 WRAP.
00000000 00000000 00 1 0
00000001 00000000 00 1 0
00000000 00000010 0f 1 0
00000001 00000010 0f 1 0
00000000 00000080 03 1 0
00000001 00000080 03 1 0
00000000 000000f8 07 1 0
00000000 00000100 07 0 0
00000001 00000100 05 0 0
00000001 000000f8 07 1 0
00000000 000003e0 07 1 0
00000000 000003f8 05 1 2
00000001 000003e0 0f 1 2
00000001 00000800 03 1 2
00000000 00000040 03 2 2
00000001 00000040 03 1 0
00000001 00000040 03 2 2
00000000 00000300 07 1 0
00000002 00000100 07 1 0
00000001 00000300 07 1 0
00000001 00000100 07 1 0
00000003 00000020 00 0 0
00000003 000000c0 00 0 0

/* compile.f */
hdl/axi_pkg.sv
hdl/bfm_regs_pkg.sv
hdl/axi4_if.sv
hdl/burst_regs.sv
hdl/axi_write_master.sv
hdl/axi_read_master.sv
hdl/axi_burst_mem.sv
hdl/axi_burst_top.sv
test/tb_axi_burst.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the burst master testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_burst \
	-f compile.f -o tb_axi_burst
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_axi_burst > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qxF '** PASS **' "$log"; then
	exit 0
fi
exit 1
